// File: rtl/rvIsaPkg.sv
// RV32 ISA definitions of opcodes, funct7 codes and the instruction format views
package rvIsaPkg;

    localparam int xlen = 32;

    typedef logic [4:0] regIdx_t;

    // Major opcodes of the supported base and M instructions
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000;
    localparam logic [6:0] f7MulDiv = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        regIdx_t    rs2;
        regIdx_t    rs1;
        logic [2:0] funct3;
        regIdx_t    rd;
        logic [6:0] opcode;
    } rFormat_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        regIdx_t     rs1;
        logic [2:0]  funct3;
        regIdx_t     rd;
        logic [6:0]  opcode;
    } iFormat_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        regIdx_t    rs2;
        regIdx_t    rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sFormat_t;

    // Branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        regIdx_t    rs2;
        regIdx_t    rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bFormat_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        regIdx_t     rd;
        logic [6:0]  opcode;
    } uFormat_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        regIdx_t    rd;
        logic [6:0] opcode;
    } jFormat_t;

    // One instruction word seen through every format
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        sFormat_t s;
        bFormat_t b;
        uFormat_t u;
        jFormat_t j;
    } instr_t;

endpackage

// File: rtl/decodePkg.sv
// Decode pipeline types for ALU operation codes, control bundle and stage payloads
package decodePkg;

    // Codes kept compatible with the execute stage ALU
    typedef enum logic [4:0] {
        aluAnd    = 5'd0,
        aluOr     = 5'd1,
        aluAdd    = 5'd2,
        aluXor    = 5'd3,
        aluSub    = 5'd4,
        aluSll    = 5'd6,
        aluSrl    = 5'd7,
        aluSra    = 5'd8,
        aluSlt    = 5'd9,
        aluSltu   = 5'd10,
        aluMul    = 5'd11,
        aluMulh   = 5'd12,
        aluMulhsu = 5'd13,
        aluMulhu  = 5'd14,
        aluDiv    = 5'd15,
        aluDivu   = 5'd16,
        aluRem    = 5'd17,
        aluRemu   = 5'd18
    } aluOp_t;

    typedef struct packed {
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       aluSrc;
        logic       pcSrc;
        logic       illegal;
        logic [2:0] branchType;
        aluOp_t     aluOp;
    } ctrl_t;

    typedef struct packed {
        rvIsaPkg::instr_t             instr;
        logic [rvIsaPkg::xlen-1:0]    pc;
        logic [rvIsaPkg::xlen-1:0]    value1;
        logic [rvIsaPkg::xlen-1:0]    value2;
    } fetchBundle_t;

    typedef struct packed {
        ctrl_t                        ctrl;
        logic [rvIsaPkg::xlen-1:0]    imm;
        rvIsaPkg::regIdx_t            rd;
        rvIsaPkg::regIdx_t            rs1;
        rvIsaPkg::regIdx_t            rs2;
        logic [rvIsaPkg::xlen-1:0]    pc;
        logic [rvIsaPkg::xlen-1:0]    value1;
        logic [rvIsaPkg::xlen-1:0]    value2;
    } decodedBundle_t;

    localparam int fifoDepth = 2;

endpackage

// File: rtl/controlDecoder.sv
// Control decoder mapping an RV32IM instruction word to the control bundle
`timescale 1ns/1ps

module controlDecoder (
    input  rvIsaPkg::instr_t instr,
    output decodePkg::ctrl_t ctrl
);

    logic bad;

    // Shared funct3 map of OP and OP-IMM
    function automatic decodePkg::aluOp_t baseOp(input logic [2:0] f3, input logic alt);
        decodePkg::aluOp_t op;
        case (f3)
            3'b000:  op = decodePkg::aluAdd;
            3'b001:  op = decodePkg::aluSll;
            3'b010:  op = decodePkg::aluSlt;
            3'b011:  op = decodePkg::aluSltu;
            3'b100:  op = decodePkg::aluXor;
            3'b101:  op = alt ? decodePkg::aluSra : decodePkg::aluSrl;
            3'b110:  op = decodePkg::aluOr;
            default: op = decodePkg::aluAnd;
        endcase
        return op;
    endfunction

    function automatic decodePkg::aluOp_t mulDivOp(input logic [2:0] f3);
        decodePkg::aluOp_t op;
        case (f3)
            3'b000:  op = decodePkg::aluMul;
            3'b001:  op = decodePkg::aluMulh;
            3'b010:  op = decodePkg::aluMulhsu;
            3'b011:  op = decodePkg::aluMulhu;
            3'b100:  op = decodePkg::aluDiv;
            3'b101:  op = decodePkg::aluDivu;
            3'b110:  op = decodePkg::aluRem;
            default: op = decodePkg::aluRemu;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl = '0;
        bad  = 1'b0;
        case (instr.r.opcode)
            rvIsaPkg::opLui, rvIsaPkg::opAuipc:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodePkg::aluAdd;
            end
            // Jumps leave the link write to a later stage
            rvIsaPkg::opJal, rvIsaPkg::opJalr:
            begin
                ctrl.pcSrc    = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodePkg::aluAdd;
            end
            rvIsaPkg::opBranch:
            begin
                ctrl.pcSrc      = 1'b1;
                ctrl.aluOp      = decodePkg::aluSub;
                ctrl.branchType = instr.b.funct3;
            end
            rvIsaPkg::opLoad:
            begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodePkg::aluAdd;
            end
            rvIsaPkg::opStore:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodePkg::aluAdd;
            end
            rvIsaPkg::opImm:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                // Upper immediate bits pick srai over srli
                ctrl.aluOp    = baseOp(instr.r.funct3, instr.r.funct7 == rvIsaPkg::f7Alt);
            end
            rvIsaPkg::opReg:
            begin
                ctrl.regWrite = 1'b1;
                case (instr.r.funct7)
                    rvIsaPkg::f7Base:   ctrl.aluOp = baseOp(instr.r.funct3, 1'b0);
                    rvIsaPkg::f7MulDiv: ctrl.aluOp = mulDivOp(instr.r.funct3);
                    rvIsaPkg::f7Alt:
                    begin
                        if (instr.r.funct3 == 3'b000)
                            ctrl.aluOp = decodePkg::aluSub;
                        else if (instr.r.funct3 == 3'b101)
                            ctrl.aluOp = decodePkg::aluSra;
                        else
                            bad = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase

        // Unknown words carry only the illegal flag
        if (bad)
        begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

// File: rtl/immGen.sv
// Immediate generator building the sign-extended operand for each RV32 format
`timescale 1ns/1ps

module immGen (
    input  rvIsaPkg::instr_t                instr,
    output logic [rvIsaPkg::xlen-1:0]       imm
);

    always_comb
    begin
        case (instr.r.opcode)
            rvIsaPkg::opJalr, rvIsaPkg::opLoad, rvIsaPkg::opImm:
                imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
            rvIsaPkg::opStore:
                imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
            // Branch offsets are halfword aligned
            rvIsaPkg::opBranch:
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            rvIsaPkg::opLui, rvIsaPkg::opAuipc:
                imm = {instr.u.imm31_12, 12'b0};
            rvIsaPkg::opJal:
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            // OP and unknown opcodes have no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

// File: rtl/decodeStage.sv
// Decode stage register with valid/ready handshake feeding the decoder and immediate logic
`timescale 1ns/1ps

module decodeStage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inValid,
    output logic                      inReady,
    input  decodePkg::fetchBundle_t   inData,
    output logic                      stageValid,
    input  logic                      stageReady,
    output decodePkg::decodedBundle_t stageData
);

    logic                      full;
    decodePkg::fetchBundle_t   held;
    decodePkg::ctrl_t          ctrl;
    logic [rvIsaPkg::xlen-1:0] imm;

    // Accept when empty or when the held bundle moves on this cycle
    assign inReady    = !full || stageReady;
    assign stageValid = full;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            full <= 1'b0;
        else if (inReady)
            full <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid && inReady)
            held <= inData;
    end

    controlDecoder u_ctrlDec (
        .instr (held.instr),
        .ctrl  (ctrl)
    );

    immGen u_immGen (
        .instr (held.instr),
        .imm   (imm)
    );

    always_comb
    begin
        stageData.ctrl   = ctrl;
        stageData.imm    = imm;
        stageData.rd     = held.instr.r.rd;
        stageData.rs1    = held.instr.r.rs1;
        stageData.rs2    = held.instr.r.rs2;
        stageData.pc     = held.pc;
        stageData.value1 = held.value1;
        stageData.value2 = held.value2;
    end

endmodule

// File: rtl/decodeFifo.sv
// Small circular FIFO of decoded bundles with valid/ready on both sides
`timescale 1ns/1ps

module decodeFifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wrValid,
    output logic                      wrReady,
    input  decodePkg::decodedBundle_t wrData,
    output logic                      rdValid,
    input  logic                      rdReady,
    output decodePkg::decodedBundle_t rdData
);

    localparam int ptrW = (decodePkg::fifoDepth > 1) ? $clog2(decodePkg::fifoDepth) : 1;
    localparam int cntW = $clog2(decodePkg::fifoDepth + 1);

    decodePkg::decodedBundle_t mem [decodePkg::fifoDepth];
    logic [ptrW-1:0]           wrPtr;
    logic [ptrW-1:0]           rdPtr;
    logic [cntW-1:0]           count;
    logic                      wrEn;
    logic                      rdEn;

    // No bypass, so an entry shows up only after its write edge
    assign wrReady = count < cntW'(decodePkg::fifoDepth);
    assign rdValid = count != '0;
    assign rdData  = mem[rdPtr];
    assign wrEn    = wrValid && wrReady;
    assign rdEn    = rdValid && rdReady;

    always_ff @(posedge clk)
    begin
        if (wrEn)
            mem[wrPtr] <= wrData;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (wrEn)
                wrPtr <= (wrPtr == ptrW'(decodePkg::fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (rdEn)
                rdPtr <= (rdPtr == ptrW'(decodePkg::fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            // Simultaneous read and write leaves the count unchanged
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/decodeTop.sv
// Decode top level joining the stage register and the output FIFO
`timescale 1ns/1ps

module decodeTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inValid,
    output logic                      inReady,
    input  decodePkg::fetchBundle_t   inData,
    output logic                      outValid,
    input  logic                      outReady,
    output decodePkg::decodedBundle_t outData
);

    logic                      stageValid;
    logic                      stageReady;
    decodePkg::decodedBundle_t stageData;

    decodeStage u_stage (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inReady    (inReady),
        .inData     (inData),
        .stageValid (stageValid),
        .stageReady (stageReady),
        .stageData  (stageData)
    );

    decodeFifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wrValid (stageValid),
        .wrReady (stageReady),
        .wrData  (stageData),
        .rdValid (outValid),
        .rdReady (outReady),
        .rdData  (outData)
    );

endmodule

// File: tb/decodeTop_checker.sv
// Decode top checker with concurrent assertions on the output handshake and ordering
`timescale 1ns/1ps

module decodeTopChecker (
    input logic                      clk,
    input logic                      rst,
    input logic                      inValid,
    input logic                      inReady,
    input logic                      outValid,
    input logic                      outReady,
    input decodePkg::decodedBundle_t outData
);

    int unsigned failCount = 0;
    logic [2:0]  inFlight;

    // Bundles accepted at the input and not yet delivered
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            inFlight <= '0;
        else
            inFlight <= inFlight + 3'(inValid && inReady) - 3'(outValid && outReady);
    end

    resetEmpty: assert property (@(posedge clk) (rst || $fell(rst)) |-> !outValid)
        else
        begin
            failCount++;
            $error("outValid high during or right after reset");
        end

    holdStable: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outData))
        else
        begin
            failCount++;
            $error("outData changed or outValid dropped while stalled");
        end

    noPhantom: assert property (@(posedge clk) disable iff (rst) outValid |-> inFlight != '0)
        else
        begin
            failCount++;
            $error("outValid high without an accepted input bundle");
        end

    // Stage register plus two FIFO entries
    boundedFlight: assert property (@(posedge clk) disable iff (rst) inFlight <= 3'd3)
        else
        begin
            failCount++;
            $error("More than three bundles in flight");
        end

endmodule

bind decodeTop decodeTopChecker u_chk (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
);

// File: tb/decodeTb.sv
// Decode stage testbench driving RV32IM bundles and checking them against a reference decode
`timescale 1ns/1ps

module decodeTb;

    localparam int timeoutCycles = 200;

    logic                      clk;
    logic                      rst;
    logic                      inValid;
    logic                      inReady;
    decodePkg::fetchBundle_t   inData;
    logic                      outValid;
    logic                      outReady;
    decodePkg::decodedBundle_t outData;

    integer seed = 13623;
    int     cycle = 0;
    int     checks = 0;
    int     mismatches = 0;
    int     protocolErrors = 0;
    int     timeouts = 0;
    bit     latencyMode = 1'b0;
    bit     stallMode = 1'b0;

    decodePkg::fetchBundle_t   stim [$];
    decodePkg::decodedBundle_t expQ [$];
    int                        sentQ [$];

    decodeTop u_dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // Random back-pressure only in the stall phase
    always @(posedge clk)
    begin
        #1;
        outReady = stallMode ? 1'($random(seed)) : 1'b1;
    end

    function automatic logic [4:0] randReg();
        return 5'($random(seed));
    endfunction

    function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, randReg(), randReg(), f3, randReg(), rvIsaPkg::opReg};
    endfunction

    function automatic logic [31:0] iWord(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [11:0] imm);
        return {imm, randReg(), f3, randReg(), op};
    endfunction

    function automatic logic [31:0] sWord(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], randReg(), randReg(), f3, imm[4:0], rvIsaPkg::opStore};
    endfunction

    function automatic logic [31:0] bWord(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], randReg(), randReg(), f3, imm[4:1], imm[11],
                rvIsaPkg::opBranch};
    endfunction

    function automatic logic [31:0] uWord(input logic [6:0] op, input logic [19:0] imm);
        return {imm, randReg(), op};
    endfunction

    function automatic logic [31:0] jWord(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], randReg(), rvIsaPkg::opJal};
    endfunction

    task automatic queueInstr(input logic [31:0] word);
        decodePkg::fetchBundle_t b;
        b.instr  = word;
        b.pc     = 32'($random(seed)) & 32'hFFFF_FFFC;
        b.value1 = 32'($random(seed));
        b.value2 = 32'($random(seed));
        stim.push_back(b);
    endtask

    task automatic buildStream();
        logic [2:0]  loadF3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        logic [2:0]  branchF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [11:0] imm12;
        for (int f = 0; f < 8; f++)
        begin
            queueInstr(rWord(rvIsaPkg::f7Base, 3'(f)));
            queueInstr(rWord(rvIsaPkg::f7MulDiv, 3'(f)));
            // Shift amounts leave the upper immediate bits clear
            imm12 = (f == 1 || f == 5) ? {7'b0, randReg()} : 12'($random(seed));
            queueInstr(iWord(rvIsaPkg::opImm, 3'(f), imm12));
        end
        queueInstr(rWord(rvIsaPkg::f7Alt, 3'd0));
        queueInstr(rWord(rvIsaPkg::f7Alt, 3'd5));
        queueInstr(iWord(rvIsaPkg::opImm, 3'd5, {rvIsaPkg::f7Alt, randReg()}));
        // Each load and store width with a positive and a negative offset
        foreach (loadF3[k])
        begin
            queueInstr(iWord(rvIsaPkg::opLoad, loadF3[k], {1'b0, 11'($random(seed))}));
            queueInstr(iWord(rvIsaPkg::opLoad, loadF3[k], {1'b1, 11'($random(seed))}));
        end
        for (int f = 0; f < 3; f++)
        begin
            queueInstr(sWord(3'(f), {1'b0, 11'($random(seed))}));
            queueInstr(sWord(3'(f), {1'b1, 11'($random(seed))}));
        end
        foreach (branchF3[k])
            queueInstr(bWord(branchF3[k], {1'(k), 11'($random(seed)), 1'b0}));
        for (int n = 0; n < 2; n++)
        begin
            queueInstr(jWord({1'(n), 19'($random(seed)), 1'b0}));
            queueInstr(iWord(rvIsaPkg::opJalr, 3'd0, {1'(n), 11'($random(seed))}));
            queueInstr(uWord(rvIsaPkg::opLui, {1'(n), 19'($random(seed))}));
            queueInstr(uWord(rvIsaPkg::opAuipc, {1'(n), 19'($random(seed))}));
        end
        // SYSTEM, FENCE, an unused opcode and two bad OP funct7 values
        queueInstr({25'($random(seed)), 7'b1110011});
        queueInstr({25'($random(seed)), 7'b0001111});
        queueInstr({25'($random(seed)), 7'b1111111});
        queueInstr(rWord(7'b0100000, 3'd1));
        queueInstr(rWord(7'b1111111, 3'd0));
    endtask

    // ALU operation table keyed by funct7 and funct3
    function automatic decodePkg::aluOp_t aluFor(input logic [6:0] f7, input logic [2:0] f3,
                                                 output logic known);
        decodePkg::aluOp_t op;
        op    = decodePkg::aluAnd;
        known = 1'b1;
        case ({f7, f3})
            {rvIsaPkg::f7Base, 3'd0}:   op = decodePkg::aluAdd;
            {rvIsaPkg::f7Base, 3'd1}:   op = decodePkg::aluSll;
            {rvIsaPkg::f7Base, 3'd2}:   op = decodePkg::aluSlt;
            {rvIsaPkg::f7Base, 3'd3}:   op = decodePkg::aluSltu;
            {rvIsaPkg::f7Base, 3'd4}:   op = decodePkg::aluXor;
            {rvIsaPkg::f7Base, 3'd5}:   op = decodePkg::aluSrl;
            {rvIsaPkg::f7Base, 3'd6}:   op = decodePkg::aluOr;
            {rvIsaPkg::f7Base, 3'd7}:   op = decodePkg::aluAnd;
            {rvIsaPkg::f7Alt, 3'd0}:    op = decodePkg::aluSub;
            {rvIsaPkg::f7Alt, 3'd5}:    op = decodePkg::aluSra;
            {rvIsaPkg::f7MulDiv, 3'd0}: op = decodePkg::aluMul;
            {rvIsaPkg::f7MulDiv, 3'd1}: op = decodePkg::aluMulh;
            {rvIsaPkg::f7MulDiv, 3'd2}: op = decodePkg::aluMulhsu;
            {rvIsaPkg::f7MulDiv, 3'd3}: op = decodePkg::aluMulhu;
            {rvIsaPkg::f7MulDiv, 3'd4}: op = decodePkg::aluDiv;
            {rvIsaPkg::f7MulDiv, 3'd5}: op = decodePkg::aluDivu;
            {rvIsaPkg::f7MulDiv, 3'd6}: op = decodePkg::aluRem;
            {rvIsaPkg::f7MulDiv, 3'd7}: op = decodePkg::aluRemu;
            default:                    known = 1'b0;
        endcase
        return op;
    endfunction

    // Reference decode working on raw instruction bits
    function automatic decodePkg::decodedBundle_t expectDecode(input decodePkg::fetchBundle_t f);
        decodePkg::decodedBundle_t e;
        logic [31:0] w;
        logic [6:0]  f7;
        logic        known;
        w     = f.instr;
        f7    = w[31:25];
        known = 1'b1;
        e     = '0;
        case (w[6:0])
            rvIsaPkg::opLui, rvIsaPkg::opAuipc:
            begin
                e.ctrl.regWrite = 1'b1;
                e.ctrl.aluSrc   = 1'b1;
                e.ctrl.aluOp    = decodePkg::aluAdd;
                e.imm           = {w[31:12], 12'h000};
            end
            rvIsaPkg::opJal, rvIsaPkg::opJalr:
            begin
                e.ctrl.pcSrc    = 1'b1;
                e.ctrl.memToReg = 1'b1;
                e.ctrl.aluSrc   = 1'b1;
                e.ctrl.aluOp    = decodePkg::aluAdd;
                if (w[6:0] == rvIsaPkg::opJal)
                    e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                else
                    e.imm = {{21{w[31]}}, w[30:20]};
            end
            rvIsaPkg::opBranch:
            begin
                e.ctrl.pcSrc      = 1'b1;
                e.ctrl.aluOp      = decodePkg::aluSub;
                e.ctrl.branchType = w[14:12];
                e.imm             = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            rvIsaPkg::opLoad:
            begin
                e.ctrl.memRead  = 1'b1;
                e.ctrl.memToReg = 1'b1;
                e.ctrl.regWrite = 1'b1;
                e.ctrl.aluSrc   = 1'b1;
                e.ctrl.aluOp    = decodePkg::aluAdd;
                e.imm           = {{21{w[31]}}, w[30:20]};
            end
            rvIsaPkg::opStore:
            begin
                e.ctrl.memWrite = 1'b1;
                e.ctrl.aluSrc   = 1'b1;
                e.ctrl.aluOp    = decodePkg::aluAdd;
                e.imm           = {{21{w[31]}}, w[30:25], w[11:7]};
            end
            rvIsaPkg::opImm:
            begin
                e.ctrl.regWrite = 1'b1;
                e.ctrl.aluSrc   = 1'b1;
                // Only a right shift looks at the upper immediate bits
                if (w[14:12] == 3'b101 && f7 == rvIsaPkg::f7Alt)
                    e.ctrl.aluOp = aluFor(rvIsaPkg::f7Alt, w[14:12], known);
                else
                    e.ctrl.aluOp = aluFor(rvIsaPkg::f7Base, w[14:12], known);
                e.imm = {{21{w[31]}}, w[30:20]};
            end
            rvIsaPkg::opReg:
            begin
                e.ctrl.regWrite = 1'b1;
                e.ctrl.aluOp    = aluFor(f7, w[14:12], known);
            end
            default: known = 1'b0;
        endcase
        if (!known)
        begin
            e.ctrl         = '0;
            e.ctrl.illegal = 1'b1;
        end
        e.rd     = w[11:7];
        e.rs1    = w[19:15];
        e.rs2    = w[24:20];
        e.pc     = f.pc;
        e.value1 = f.value1;
        e.value2 = f.value2;
        return e;
    endfunction

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        assert (actVal === expVal)
        else
        begin
            mismatches++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expVal, actVal);
        end
    endtask

    task automatic compareBundle(input decodePkg::decodedBundle_t e,
                                 input decodePkg::decodedBundle_t a);
        checkField("regWrite", e.ctrl.regWrite, a.ctrl.regWrite);
        checkField("memRead", e.ctrl.memRead, a.ctrl.memRead);
        checkField("memWrite", e.ctrl.memWrite, a.ctrl.memWrite);
        checkField("memToReg", e.ctrl.memToReg, a.ctrl.memToReg);
        checkField("aluSrc", e.ctrl.aluSrc, a.ctrl.aluSrc);
        checkField("pcSrc", e.ctrl.pcSrc, a.ctrl.pcSrc);
        checkField("illegal", e.ctrl.illegal, a.ctrl.illegal);
        checkField("branchType", e.ctrl.branchType, a.ctrl.branchType);
        checkField("aluOp", e.ctrl.aluOp, a.ctrl.aluOp);
        checkField("imm", e.imm, a.imm);
        checkField("rd", e.rd, a.rd);
        checkField("rs1", e.rs1, a.rs1);
        checkField("rs2", e.rs2, a.rs2);
        checkField("pc", e.pc, a.pc);
        checkField("value1", e.value1, a.value1);
        checkField("value2", e.value2, a.value2);
    endtask

    // Handshakes sampled mid-cycle once inputs and outputs have settled
    always @(negedge clk)
    begin
        decodePkg::decodedBundle_t expected;
        int sentCycle;
        if (!rst)
        begin
            checkField("inReady", expQ.size() < 3, inReady);
            if (outValid && outReady)
            begin
                assert (expQ.size() != 0)
                else
                begin
                    protocolErrors++;
                    $display("Output bundle at %0t has no matching input bundle", $time);
                end
                if (expQ.size() != 0)
                begin
                    expected  = expQ.pop_front();
                    sentCycle = sentQ.pop_front();
                    compareBundle(expected, outData);
                    if (latencyMode)
                        checkField("latency", 2, cycle - sentCycle);
                end
            end
            if (inValid && inReady)
            begin
                expQ.push_back(expectDecode(inData));
                sentQ.push_back(cycle);
            end
        end
    end

    task automatic sendBundle(input decodePkg::fetchBundle_t b);
        int waited;
        inValid = 1'b1;
        inData  = b;
        waited  = 0;
        @(negedge clk);
        while (!inReady && waited < timeoutCycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (!inReady)
        begin
            timeouts++;
            $display("Timeout: inReady stayed low for %0d cycles", timeoutCycles);
        end
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < timeoutCycles)
        begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0)
        begin
            timeouts++;
            $display("Timeout: %0d bundles never reached the output", expQ.size());
        end
        @(posedge clk);
        #1;
    endtask

    task automatic runStream(input bit idleGaps);
        foreach (stim[k])
        begin
            if (timeouts != 0)
                break;
            sendBundle(stim[k]);
            if (idleGaps && (($random(seed) & 3) == 0))
            begin
                @(posedge clk);
                #1;
            end
        end
        drain();
    endtask

    initial
    begin
        rst      = 1'b1;
        inValid  = 1'b0;
        inData   = '0;
        outReady = 1'b0;
        buildStream();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Lone bundle into an empty pipeline, then the stream at full rate
        latencyMode = 1'b1;
        sendBundle(stim[0]);
        drain();
        runStream(1'b0);
        latencyMode = 1'b0;

        stallMode = 1'b1;
        runStream(1'b1);
        stallMode = 1'b0;
        drain();

        $display("Checks %0d, mismatches %0d, protocol errors %0d, timeouts %0d, assertions %0d",
                 checks, mismatches, protocolErrors, timeouts, u_dut.u_chk.failCount);
        if (mismatches == 0 && protocolErrors == 0 && timeouts == 0 &&
            u_dut.u_chk.failCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: files.f
rtl/rvIsaPkg.sv
rtl/decodePkg.sv
rtl/controlDecoder.sv
rtl/immGen.sv
rtl/decodeStage.sv
rtl/decodeFifo.sv
rtl/decodeTop.sv
tb/decodeTop_checker.sv
tb/decodeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= decodeTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
